/* logic/ppu_pkg.sv */
// PPU shared definitions
// Screen geometry, register codes and bus structs

package ppu_pkg;

    // Screen geometry, in dots and lines
    localparam logic [8:0] SCREEN_WIDTH          = 9'd341;
    localparam logic [8:0] SCREEN_HEIGHT         = 9'd262;
    localparam logic [8:0] SCREEN_VISIBLE_WIDTH  = 9'd256;
    localparam logic [8:0] SCREEN_VISIBLE_HEIGHT = 9'd240;

    localparam logic [8:0] VBLANK_SET_LINE   = 9'd241; // Flag sets at dot 1
    localparam logic [8:0] VBLANK_CLEAR_LINE = 9'd261; // Pre-render line, flag clears at dot 1

    // CPU register select codes
    localparam logic [2:0] RS_PPUCTRL   = 3'd0;
    localparam logic [2:0] RS_PPUMASK   = 3'd1;
    localparam logic [2:0] RS_PPUSTATUS = 3'd2;
    localparam logic [2:0] RS_PPUADDR   = 3'd6;
    localparam logic [2:0] RS_PPUDATA   = 3'd7;

    localparam logic [5:0] PALETTE_BASE = 6'h3F; // VRAM 3F00-3FFF maps to palette RAM

    // System colour table, relative to the project root
    localparam string COLOR_TABLE_FILE = "logic/ppu_colors.mem";

    // Decoded CPU access, register side to VRAM side
    typedef struct packed {
        logic       addr_wr;   // PPUADDR write strobe
        logic       data_wr;   // PPUDATA write strobe
        logic       data_rd;   // PPUDATA read strobe
        logic       status_rd; // PPUSTATUS read, resets write toggle
        logic       inc32;     // PPUCTRL bit 2, step of 32
        logic [7:0] wdata;     // CPU write data
    } ppu_vram_cmd_t;

    // Current raster position
    typedef struct packed {
        logic [8:0] x;
        logic [8:0] y;
        logic       visible;
    } ppu_raster_t;

    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } ppu_rgb_t;

endpackage

/* logic/ppu_regs.sv */
// PPU CPU register file
// Decode, control registers, vblank flag and NMI

`timescale 1ns/1ps

module ppu_regs (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  logic                   i_cs_n,
    input  logic                   i_rw,          // 1 = read, 0 = write
    input  logic [2:0]             i_rs,
    input  logic [7:0]             i_data,
    output logic [7:0]             o_data,
    output logic                   o_int_n,
    input  logic                   i_vblank_start,
    input  logic                   i_vblank_end,
    output ppu_pkg::ppu_vram_cmd_t o_cmd,
    input  logic [7:0]             i_rdata,       // PPUDATA read value
    output logic                   o_greyscale,
    output logic [7:0]             o_debug_ppuctrl,
    output logic [7:0]             o_debug_ppumask
);
    import ppu_pkg::*;

    logic [7:0] r_ppuctrl;
    logic [7:0] r_ppumask;
    logic       r_vblank;     // NMI_occurred, read as PPUSTATUS bit 7
    logic       r_int_n;

    logic       w_rd;
    logic       w_wr;

    assign w_rd = !i_cs_n && i_rw;
    assign w_wr = !i_cs_n && !i_rw;

    // Control registers, written at the end of the access cycle
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_ppuctrl <= 8'h00;
            r_ppumask <= 8'h00;
        end
        else if (w_wr)
        begin
            if (i_rs == RS_PPUCTRL)
                r_ppuctrl <= i_data;
            if (i_rs == RS_PPUMASK)
                r_ppumask <= i_data;
        end
    end

    // Vblank flag; a set in the same cycle beats a clear
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_vblank <= 1'b0;
        else if (i_vblank_start)
            r_vblank <= 1'b1;
        else if (i_vblank_end || o_cmd.status_rd)
            r_vblank <= 1'b0;
    end

    // NMI out, one register stage behind flag and enable
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
            r_int_n <= 1'b1;
        else
            r_int_n <= !(r_vblank && r_ppuctrl[7]);
    end

    // Strobes toward the VRAM port
    assign o_cmd.addr_wr   = w_wr && (i_rs == RS_PPUADDR);
    assign o_cmd.data_wr   = w_wr && (i_rs == RS_PPUDATA);
    assign o_cmd.data_rd   = w_rd && (i_rs == RS_PPUDATA);
    assign o_cmd.status_rd = w_rd && (i_rs == RS_PPUSTATUS);
    assign o_cmd.inc32     = r_ppuctrl[2];
    assign o_cmd.wdata     = i_data;

    // CPU read mux, only live in a read cycle
    always_comb
    begin
        o_data = 8'h00;
        if (w_rd)
        begin
            case (i_rs)
                RS_PPUSTATUS: o_data = {r_vblank, 7'b0000000};
                RS_PPUDATA:   o_data = i_rdata;
                default:      o_data = 8'h00; // Write-only or unmodelled
            endcase
        end
    end

    assign o_int_n         = r_int_n;
    assign o_greyscale     = r_ppumask[0];
    assign o_debug_ppuctrl = r_ppuctrl;
    assign o_debug_ppumask = r_ppumask;

endmodule

/* logic/ppu_raster.sv */
// PPU raster counter

`timescale 1ns/1ps

module ppu_raster (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    output ppu_pkg::ppu_raster_t o_raster,
    output logic                 o_vblank_start,
    output logic                 o_vblank_end
);
    import ppu_pkg::*;

    logic [8:0] r_x;  // Dot within line
    logic [8:0] r_y;  // Line within frame

    // Dot counter with carry into the line counter
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_x <= 9'd0;
            r_y <= 9'd0;
        end
        else if (r_x != SCREEN_WIDTH - 9'd1)
            r_x <= r_x + 9'd1;
        else
        begin
            r_x <= 9'd0; // End of line
            if (r_y != SCREEN_HEIGHT - 9'd1)
                r_y <= r_y + 9'd1;
            else
                r_y <= 9'd0;
        end
    end

    assign o_raster.x       = r_x;
    assign o_raster.y       = r_y;
    assign o_raster.visible = (r_x < SCREEN_VISIBLE_WIDTH) && (r_y < SCREEN_VISIBLE_HEIGHT);

    // Strobes at dot 1 of the set and clear lines
    assign o_vblank_start = (r_x == 9'd1) && (r_y == VBLANK_SET_LINE);
    assign o_vblank_end   = (r_x == 9'd1) && (r_y == VBLANK_CLEAR_LINE);

endmodule

/* logic/ppu_vram_port.sv */
// PPU VRAM port and palette RAM

`timescale 1ns/1ps

module ppu_vram_port (
    input  logic                   i_clk,
    input  logic                   i_reset_n,
    input  ppu_pkg::ppu_vram_cmd_t i_cmd,
    output logic [7:0]             o_rdata,
    output logic                   o_video_rd_n,
    output logic                   o_video_we_n,
    output logic [13:0]            o_video_address,
    output logic [7:0]             o_video_data,
    input  logic [7:0]             i_video_data,
    output logic [5:0]             o_backdrop
);
    import ppu_pkg::*;

    logic [13:0] r_addr;             // Current VRAM address
    logic        r_toggle;           // 0 = next PPUADDR write is the high byte
    logic [7:0]  r_buffer;           // PPUDATA read buffer
    logic [7:0]  r_wdata;
    logic        r_we_cycle;         // Bus write in progress
    logic        r_rd_cycle;         // Bus read in progress
    logic [5:0]  r_palette [0:31];

    logic        w_is_palette;
    logic [4:0]  w_pal_index;
    logic [13:0] w_addr_next;

    assign w_is_palette = (r_addr[13:8] == PALETTE_BASE);

    // Entries 10/14/18/1C fold onto 00/04/08/0C
    assign w_pal_index = (r_addr[1:0] == 2'b00) ? {1'b0, r_addr[3:0]} : r_addr[4:0];

    assign w_addr_next = r_addr + (i_cmd.inc32 ? 14'd32 : 14'd1); // Wraps at 14 bits

    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            r_addr     <= 14'd0;
            r_toggle   <= 1'b0;
            r_buffer   <= 8'h00;
            r_wdata    <= 8'h00;
            r_we_cycle <= 1'b0;
            r_rd_cycle <= 1'b0;
            for (int i = 0; i < 32; i++)
                r_palette[i] <= 6'd0;
        end
        else
        begin
            r_we_cycle <= 1'b0; // Bus strobes last one cycle
            r_rd_cycle <= 1'b0;

            if (r_we_cycle || r_rd_cycle)
            begin
                // Bus cycle ends here, step the address
                r_addr <= w_addr_next;
                if (r_rd_cycle)
                    r_buffer <= i_video_data;
            end
            else if (i_cmd.addr_wr)
            begin
                if (!r_toggle)
                    r_addr[13:8] <= i_cmd.wdata[5:0]; // High bits first
                else
                    r_addr[7:0] <= i_cmd.wdata;
                r_toggle <= !r_toggle;
            end
            else if (i_cmd.data_wr)
            begin
                if (w_is_palette)
                begin
                    // Palette is internal, no bus cycle needed
                    r_palette[w_pal_index] <= i_cmd.wdata[5:0];
                    r_addr                 <= w_addr_next;
                end
                else
                begin
                    r_wdata    <= i_cmd.wdata;
                    r_we_cycle <= 1'b1;
                end
            end
            else if (i_cmd.data_rd)
                r_rd_cycle <= 1'b1;  // Refill buffer from the bus next cycle

            if (i_cmd.status_rd)
                r_toggle <= 1'b0;
        end
    end

    // Palette reads bypass the buffer
    assign o_rdata = w_is_palette ? {2'b00, r_palette[w_pal_index]} : r_buffer;

    assign o_video_rd_n    = !r_rd_cycle;
    assign o_video_we_n    = !r_we_cycle;
    assign o_video_address = r_addr;
    assign o_video_data    = r_wdata;
    assign o_backdrop      = r_palette[0]; // Universal background colour

endmodule

/* logic/ppu_pixel_out.sv */
// PPU pixel output stage

`timescale 1ns/1ps

module ppu_pixel_out (
    input  logic                 i_clk,
    input  logic                 i_reset_n,
    input  ppu_pkg::ppu_raster_t i_raster,
    input  logic [5:0]           i_backdrop,
    input  logic                 i_greyscale,
    output ppu_pkg::ppu_rgb_t    o_rgb,
    output logic [8:0]           o_video_x,
    output logic [8:0]           o_video_y,
    output logic                 o_video_visible
);
    import ppu_pkg::*;

    ppu_rgb_t   r_colors [0:63]; // System colour ROM
    logic [5:0] w_index;

    initial
    begin
        $readmemh(COLOR_TABLE_FILE, r_colors);
    end

    // Greyscale keeps only the luma column
    assign w_index = i_greyscale ? (i_backdrop & 6'h30) : i_backdrop;

    // Colour and position leave on the same edge
    always_ff @(posedge i_clk)
    begin
        if (!i_reset_n)
        begin
            o_rgb           <= '0;
            o_video_x       <= 9'd0;
            o_video_y       <= 9'd0;
            o_video_visible <= 1'b0;
        end
        else
        begin
            o_rgb           <= i_raster.visible ? r_colors[w_index] : '0; // Black in blanking
            o_video_x       <= i_raster.x;
            o_video_y       <= i_raster.y;
            o_video_visible <= i_raster.visible;
        end
    end

endmodule

/* logic/ppu.sv */
// PPU top level, 2C02 style

`timescale 1ns/1ps

module ppu (
    input  logic        i_clk,
    input  logic        i_reset_n,

    // CPU side
    input  logic        i_cs_n,
    input  logic        i_rw,
    input  logic [2:0]  i_rs,
    input  logic [7:0]  i_data,
    output logic [7:0]  o_data,
    output logic        o_int_n,         // To CPU NMI

    // Video bus
    output logic        o_video_rd_n,
    output logic        o_video_we_n,
    output logic [13:0] o_video_address,
    output logic [7:0]  o_video_data,
    input  logic [7:0]  i_video_data,

    // Pixel stream
    output logic [7:0]  o_video_red,
    output logic [7:0]  o_video_green,
    output logic [7:0]  o_video_blue,
    output logic [8:0]  o_video_x,
    output logic [8:0]  o_video_y,
    output logic        o_video_visible,

    output logic [7:0]  o_debug_ppuctrl,
    output logic [7:0]  o_debug_ppumask
);
    import ppu_pkg::*;

    ppu_vram_cmd_t w_cmd;
    ppu_raster_t   w_raster;
    ppu_rgb_t      w_rgb;
    logic [7:0]    w_rdata;
    logic [5:0]    w_backdrop;
    logic          w_greyscale;
    logic          w_vblank_start;
    logic          w_vblank_end;

    ppu_regs regs_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n),
        .i_cs_n(i_cs_n), .i_rw(i_rw), .i_rs(i_rs), .i_data(i_data),
        .o_data(o_data), .o_int_n(o_int_n),
        .i_vblank_start(w_vblank_start), .i_vblank_end(w_vblank_end),
        .o_cmd(w_cmd), .i_rdata(w_rdata), .o_greyscale(w_greyscale),
        .o_debug_ppuctrl(o_debug_ppuctrl), .o_debug_ppumask(o_debug_ppumask)
    );

    ppu_raster raster_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .o_raster(w_raster),
        .o_vblank_start(w_vblank_start), .o_vblank_end(w_vblank_end)
    );

    ppu_vram_port vram_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_cmd(w_cmd), .o_rdata(w_rdata),
        .o_video_rd_n(o_video_rd_n), .o_video_we_n(o_video_we_n),
        .o_video_address(o_video_address), .o_video_data(o_video_data),
        .i_video_data(i_video_data), .o_backdrop(w_backdrop)
    );

    ppu_pixel_out pixel_i (
        .i_clk(i_clk), .i_reset_n(i_reset_n), .i_raster(w_raster),
        .i_backdrop(w_backdrop), .i_greyscale(w_greyscale), .o_rgb(w_rgb),
        .o_video_x(o_video_x), .o_video_y(o_video_y), .o_video_visible(o_video_visible)
    );

    // Split colour struct onto the pins
    assign o_video_red   = w_rgb.red;
    assign o_video_green = w_rgb.green;
    assign o_video_blue  = w_rgb.blue;

endmodule

/* sim/ppu_chk.sv */
// PPU interface assertions

`timescale 1ns/1ps

module ppu_chk (
    input logic       i_clk,
    input logic       i_reset_n,
    input logic       i_int_n,
    input logic       i_video_rd_n,
    input logic       i_video_we_n,
    input logic [8:0] i_video_x,
    input logic [8:0] i_video_y
);
    import ppu_pkg::*;

    // NMI released through reset and the cycle after it
    int_n_reset: assert property (@(posedge i_clk) !i_reset_n |=> i_int_n)
        else $error("o_int_n low during or right after reset");

    // One bus direction at a time
    bus_exclusive: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        i_video_rd_n || i_video_we_n)
        else $error("o_video_rd_n and o_video_we_n low together");

    position_range: assert property (@(posedge i_clk) disable iff (!i_reset_n)
        (i_video_x < SCREEN_WIDTH) && (i_video_y < SCREEN_HEIGHT))
        else $error("Video position outside the frame");

endmodule

bind ppu ppu_chk chk_i (
    .i_clk(i_clk), .i_reset_n(i_reset_n), .i_int_n(o_int_n),
    .i_video_rd_n(o_video_rd_n), .i_video_we_n(o_video_we_n),
    .i_video_x(o_video_x), .i_video_y(o_video_y)
);

/* sim/ppu_tb.sv */
// PPU testbench with reference model

`timescale 1ns/1ps

module ppu_tb;
    import ppu_pkg::*;

    localparam int     FRAME_CYCLES = int'(SCREEN_WIDTH) * int'(SCREEN_HEIGHT);
    localparam int     RESET_CYCLES = 8;
    localparam int     RUN_CYCLES   = 3 * FRAME_CYCLES;
    localparam longint TIMEOUT_NS   = longint'(RUN_CYCLES + 4000) * 20; // 3 frames plus margin

    logic        clk, reset_n, cs_n, rw;
    logic [2:0]  rs;
    logic [7:0]  cpu_wdata, cpu_rdata, video_wdata, video_rdata;
    logic        int_n, video_rd_n, video_we_n, video_visible;
    logic [13:0] video_addr;
    logic [7:0]  red, green, blue, debug_ctrl, debug_mask;
    logic [8:0]  video_x, video_y;

    logic [7:0]  vram [0:16383];   // Bus-side VRAM
    logic [7:0]  m_vram [0:16383]; // Expected VRAM contents
    logic [23:0] colors [0:63];
    logic [5:0]  m_pal [0:31];
    logic [7:0]  m_ctrl, m_mask, m_buffer, m_wdata;
    logic        m_vblank, m_int_n, m_toggle, m_we, m_rd;
    logic [8:0]  m_x, m_y, exp_x, exp_y;
    logic [13:0] m_addr;
    logic        exp_vis;
    logic [23:0] exp_rgb;
    int          seed, gap, error_count, check_count;

    ppu dut_i (
        .i_clk(clk), .i_reset_n(reset_n), .i_cs_n(cs_n), .i_rw(rw), .i_rs(rs),
        .i_data(cpu_wdata), .o_data(cpu_rdata), .o_int_n(int_n),
        .o_video_rd_n(video_rd_n), .o_video_we_n(video_we_n),
        .o_video_address(video_addr), .o_video_data(video_wdata), .i_video_data(video_rdata),
        .o_video_red(red), .o_video_green(green), .o_video_blue(blue),
        .o_video_x(video_x), .o_video_y(video_y), .o_video_visible(video_visible),
        .o_debug_ppuctrl(debug_ctrl), .o_debug_ppumask(debug_mask)
    );

    always #10 clk = ~clk;

    assign video_rdata = vram[video_addr]; // Asynchronous read
    always @(posedge clk)
    begin
        if (!video_we_n)
            vram[video_addr] <= video_wdata;
    end

    function automatic logic [7:0] vram_fill(input int a);
        return 8'(a) ^ 8'(a >> 8) ^ 8'(a >> 3); // Mixes all 14 address bits
    endfunction

    // Palette slot with 10/14/18/1C folded onto the backdrop entries
    function automatic logic [4:0] pal_slot(input logic [13:0] addr);
        logic [4:0] slot;
        slot = addr[4:0];
        if (slot[1:0] == 2'b00)
            slot[4] = 1'b0;
        return slot;
    endfunction

    task automatic expect_equal(input string name, input logic [31:0] got,
                                input logic [31:0] expected);
        check_count++;
        if (got !== expected)
        begin
            error_count++;
            $display("[ERROR] %0t %s got %0h expected %0h", $time, name, got, expected);
        end
    endtask

    // One clock edge of the reference model from the inputs held over that edge
    task automatic advance_model();
        logic        rd, wr, busy;
        logic [5:0]  idx;
        logic [13:0] next_addr;
        if (!reset_n)
        begin
            {m_ctrl, m_mask, m_buffer, m_wdata} = '0;
            {m_vblank, m_toggle, m_we, m_rd, exp_vis} = '0;
            {m_x, m_y, exp_x, exp_y, m_addr, exp_rgb} = '0;
            m_int_n = 1'b1;
            for (int i = 0; i < 32; i++)
                m_pal[i] = 6'd0;
        end
        else
        begin
            rd        = !cs_n && rw;
            wr        = !cs_n && !rw;
            busy      = m_we || m_rd;
            next_addr = m_addr + (m_ctrl[2] ? 14'd32 : 14'd1);
            idx       = m_mask[0] ? {m_pal[0][5:4], 4'h0} : m_pal[0]; // Greyscale keeps the top two bits
            exp_vis   = (m_x < 9'd256) && (m_y < 9'd240);
            exp_x     = m_x;
            exp_y     = m_y;
            exp_rgb   = exp_vis ? colors[idx] : 24'h0;
            m_int_n   = !(m_vblank && m_ctrl[7]);
            if (m_x == 9'd1 && m_y == 9'd241)
                m_vblank = 1'b1;               // Set beats a same-cycle status read
            else if ((m_x == 9'd1 && m_y == 9'd261) || (rd && rs == RS_PPUSTATUS))
                m_vblank = 1'b0;
            if (m_we)
                m_vram[m_addr] = m_wdata;
            if (m_rd)
                m_buffer = m_vram[m_addr];
            m_we = 1'b0;
            m_rd = 1'b0;
            if (busy)
                m_addr = next_addr;
            else if (wr && rs == RS_PPUADDR)
            begin
                if (m_toggle)
                    m_addr[7:0] = cpu_wdata;
                else
                    m_addr[13:8] = cpu_wdata[5:0];
                m_toggle = !m_toggle;
            end
            else if (wr && rs == RS_PPUDATA && m_addr[13:8] == 6'h3F)
            begin
                m_pal[pal_slot(m_addr)] = cpu_wdata[5:0];
                m_addr = next_addr;
            end
            else if (wr && rs == RS_PPUDATA)
            begin
                m_wdata = cpu_wdata;
                m_we    = 1'b1;
            end
            else if (rd && rs == RS_PPUDATA)
                m_rd = 1'b1;
            if (rd && rs == RS_PPUSTATUS)
                m_toggle = 1'b0;
            if (wr && rs == RS_PPUCTRL)
                m_ctrl = cpu_wdata;
            if (wr && rs == RS_PPUMASK)
                m_mask = cpu_wdata;
            m_x = (m_x == 9'd340) ? 9'd0 : m_x + 9'd1;
            if (m_x == 9'd0)
                m_y = (m_y == 9'd261) ? 9'd0 : m_y + 9'd1;
        end
    endtask

    task automatic check_registered();
        expect_equal("o_video_x", video_x, exp_x);
        expect_equal("o_video_y", video_y, exp_y);
        expect_equal("o_video_visible", video_visible, exp_vis);
        expect_equal("o_video_red", red, exp_rgb[23:16]);
        expect_equal("o_video_green", green, exp_rgb[15:8]);
        expect_equal("o_video_blue", blue, exp_rgb[7:0]);
        expect_equal("o_int_n", int_n, m_int_n);
        expect_equal("o_debug_ppuctrl", debug_ctrl, m_ctrl);
        expect_equal("o_debug_ppumask", debug_mask, m_mask);
        expect_equal("o_video_we_n", video_we_n, !m_we);
        expect_equal("o_video_rd_n", video_rd_n, !m_rd);
        expect_equal("o_video_address", video_addr, m_addr);
        if (m_we)
            expect_equal("o_video_data", video_wdata, m_wdata);
    endtask

    task automatic check_cpu_read();
        logic [7:0] expected;
        expected = 8'h00;                  // Idle, writes and write-only registers
        if (!cs_n && rw && rs == RS_PPUSTATUS)
            expected = {m_vblank, 7'b0};
        else if (!cs_n && rw && rs == RS_PPUDATA)
            expected = (m_addr[13:8] == 6'h3F) ? {2'b00, m_pal[pal_slot(m_addr)]} : m_buffer;
        expect_equal("o_data", cpu_rdata, expected);
    endtask

    // Random access after a random idle gap of 1 to 16 cycles
    task automatic drive_inputs(input int cycle);
        int r;
        reset_n   = (cycle >= RESET_CYCLES - 1);
        cs_n      = 1'b1;
        rw        = 1'b1;
        rs        = 3'd0;
        cpu_wdata = 8'h00;
        if (gap > 0)
            gap--;
        else if (reset_n)
        begin
            r         = $random(seed);
            cs_n      = 1'b0;
            cpu_wdata = 8'($random(seed));
            gap       = 1 + r[15:12];
            case (r[3:0])
                4'd0, 4'd1: {rw, rs} = {1'b0, RS_PPUCTRL};
                4'd2:       {rw, rs} = {1'b0, RS_PPUMASK};
                4'd3:       {rw, rs} = {1'b1, RS_PPUSTATUS};
                4'd4, 4'd5, 4'd6:
                begin
                    {rw, rs} = {1'b0, RS_PPUADDR};
                    if (r[8])
                        cpu_wdata = 8'h3F;     // Steer toward the palette
                end
                4'd7, 4'd8, 4'd9:    {rw, rs} = {1'b0, RS_PPUDATA};
                4'd10, 4'd11, 4'd12: {rw, rs} = {1'b1, RS_PPUDATA};
                4'd13: {rw, rs} = {1'b1, r[5] ? 3'd3 + {r[4], 1'b0} : {2'b00, r[4]}};
                default: cs_n = 1'b1;
            endcase
        end
    endtask

    initial
    begin
        seed        = 48839;
        clk         = 1'b0;
        reset_n     = 1'b0;
        cs_n        = 1'b1;
        rw          = 1'b1;
        rs          = 3'd0;
        cpu_wdata   = 8'h00;
        gap         = 0;
        error_count = 0;
        check_count = 0;
        $readmemh(COLOR_TABLE_FILE, colors);
        for (int a = 0; a < 16384; a++)
        begin
            vram[a]   = vram_fill(a);
            m_vram[a] = vram_fill(a);
        end
        for (int cycle = 0; cycle < RUN_CYCLES; cycle++)
        begin
            @(negedge clk);
            advance_model();
            check_registered();
            drive_inputs(cycle);
            #2;
            check_cpu_read();              // Combinational read data settles well before the edge
        end
        $display("Checks run: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

    initial
    begin
        #(TIMEOUT_NS);
        $display("Watchdog expired before the test loop finished");
        $display("Regression failed");
        $finish;
    end

endmodule

/* project.f */
logic/ppu_pkg.sv
logic/ppu_regs.sv
logic/ppu_raster.sv
logic/ppu_vram_port.sv
logic/ppu_pixel_out.sv
logic/ppu.sv
sim/ppu_chk.sv
sim/ppu_tb.sv

/* logic/ppu_colors.mem */
// 2C02 system colours, one 24-bit RGB word per line, entries 00 to 3F
545454
001E74
081090
300088
440064
5C0030
540400
3C1800
202A00
083A00
004000
003C00
00323C
000000
000000
000000
989698
084CC4
3032EC
5C1EE4
8814B0
A01464
982220
783C00
545A00
287200
087C00
007628
006678
000000
000000
000000
ECEEEC
4C9AEC
787CEC
B062EC
E454EC
EC58B4
EC6A64
D48820
A0AA00
74C400
4CD020
38CC6C
38B4CC
3C3C3C
000000
000000
ECEEEC
A8CCEC
BCBCEC
D4B2EC
ECAEEC
ECAED4
ECB4B0
E4C490
CCD278
B4DE78
A8E290
98E2B4
A0D6E4
A0A2A0
000000
000000
